// ==== trainer_settings.svh ====
//////////////////////////////////////////////////
// Trainer settings
// Fixed-point word format, size limits and
// depth of the activation delta pipeline
//////////////////////////////////////////////////

`ifndef TRAINER_SETTINGS_SVH
`define TRAINER_SETTINGS_SVH

// Signed Q7.8 data word
`define TRAINER_DATA_W 16
`define TRAINER_FRAC_W 8

// Size limits of one training run
`define TRAINER_MAX_L 4   // Lanes
`define TRAINER_MAX_X 4   // Inputs
`define TRAINER_MAX_T 15  // Time steps

// Cycles from an accepted lane beat to its delta
`define TRAINER_DELTA_LAT 2

`endif

// ==== trainer_pkg.sv ====
//////////////////////////////////////////////////
// Trainer package
// Data, size, beat and command types plus the
// shared fixed-point multiply
//////////////////////////////////////////////////

`include "trainer_settings.svh"

package trainer_pkg;

  typedef logic signed [`TRAINER_DATA_W-1:0] data_t;
  typedef logic [1:0] lidx_t;  // Lane index
  typedef logic [1:0] xidx_t;  // Input index
  typedef logic [3:0] step_t;  // Time-step count, up to TRAINER_MAX_T

  // Run sizes, lanes and inputs coded as count minus one
  typedef struct packed {
    lidx_t size_l;
    xidx_t size_x;
    step_t size_t;
  } sizes_t;

  // One lane of forward-pass data
  typedef struct packed {
    data_t a;  // Activation
    data_t i;  // Input gate
    data_t s;  // State gradient
  } lane_t;

  typedef struct packed {
    logic  valid;
    lidx_t index;
    data_t value;
  } delta_beat_t;

  typedef struct packed {
    logic  valid;
    xidx_t index;
    data_t value;
  } x_beat_t;

  // Accumulator opcodes
  typedef enum logic [2:0] {
    ACC_NOP,
    ACC_CLEAR,
    ACC_MAC_W,
    ACC_READ_W,
    ACC_READ_B
  } acc_op_t;

  typedef struct packed {
    acc_op_t op;
    lidx_t   l_idx;
    xidx_t   x_idx;
  } acc_cmd_t;

  // Controller phases
  typedef enum logic [2:0] {
    IDLE_PHASE,
    CLEAR_PHASE,
    LANE_PHASE,
    DRAIN_PHASE,
    MAC_PHASE,
    READ_W_PHASE,
    READ_B_PHASE,
    DONE_PHASE
  } phase_t;

  // Q7.8 product, arithmetic shift then wrap to one word
  function automatic data_t fx_mul(input data_t x, input data_t y);
    logic signed [2*`TRAINER_DATA_W-1:0] prod;
    prod = x * y;
    return prod[`TRAINER_FRAC_W +: `TRAINER_DATA_W];
  endfunction

endpackage

// ==== activation_delta.sv ====
//////////////////////////////////////////////////
// Activation delta pipeline
// da = s * i * (1 - a^2) in two register stages,
// one lane beat accepted per cycle
//////////////////////////////////////////////////

`include "trainer_settings.svh"

module activation_delta (
  input  logic                     CLK,
  input  logic                     RST,
  input  trainer_pkg::lane_t       lane_in,
  input  logic                     lane_enable,
  input  trainer_pkg::lidx_t       lane_tag,
  output trainer_pkg::delta_beat_t delta_beat
);

  import trainer_pkg::*;

  // 1.0 in Q7.8
  localparam data_t ONE = data_t'(1 << `TRAINER_FRAC_W);

  // Stage 1
  logic  s1_valid;
  lidx_t s1_tag;
  data_t s1_si;  // s * i
  data_t s1_aa;  // a * a

  // Stage 2
  logic  s2_valid;
  lidx_t s2_tag;
  data_t s2_da;

  //////////////////////////////////////////////////
  // Valid pipe
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= lane_enable;
      s2_valid <= s1_valid;  // Two beats can be in flight
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    s1_tag <= lane_tag;
    s1_si  <= fx_mul(lane_in.s, lane_in.i);
    s1_aa  <= fx_mul(lane_in.a, lane_in.a);
    // Derivative of tanh folded in here
    s2_tag <= s1_tag;
    s2_da  <= fx_mul(s1_si, ONE - s1_aa);  // Difference wraps like every sum
  end

  assign delta_beat = '{valid: s2_valid, index: s2_tag, value: s2_da};

endmodule

// ==== gradient_accumulator.sv ====
//////////////////////////////////////////////////
// Gradient accumulator
// Buffers one step of deltas and inputs, sums
// dW with one MAC per cycle and db per delta,
// and streams both arrays out on read commands
//////////////////////////////////////////////////

`include "trainer_settings.svh"

module gradient_accumulator (
  input  logic                     CLK,
  input  logic                     RST,
  input  trainer_pkg::delta_beat_t delta_beat,
  input  trainer_pkg::x_beat_t     x_beat,
  input  trainer_pkg::acc_cmd_t    acc_cmd,
  output trainer_pkg::data_t       w_out,
  output logic                     w_out_enable,
  output trainer_pkg::data_t       b_out,
  output logic                     b_out_enable
);

  import trainer_pkg::*;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  data_t delta_buf [`TRAINER_MAX_L];  // Deltas of the current step
  data_t x_buf     [`TRAINER_MAX_X];  // Inputs of the current step

  data_t dw [`TRAINER_MAX_L][`TRAINER_MAX_X];  // Weight gradient
  data_t db [`TRAINER_MAX_L];                  // Bias gradient

  data_t mac_term;

  // Product for the addressed (l, x) pair
  assign mac_term = fx_mul(delta_buf[acc_cmd.l_idx], x_buf[acc_cmd.x_idx]);

  // Step buffers, overwritten each step
  always_ff @(posedge CLK) begin
    if (delta_beat.valid) begin
      delta_buf[delta_beat.index] <= delta_beat.value;
    end
    if (x_beat.valid) begin
      x_buf[x_beat.index] <= x_beat.value;
    end
  end

  //////////////////////////////////////////////////
  // Accumulation
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // db sums every delta as it lands
    if (delta_beat.valid) begin
      db[delta_beat.index] <= db[delta_beat.index] + delta_beat.value;
    end

    case (acc_cmd.op)
      ACC_CLEAR: begin
        // Start of a run, zero both arrays
        for (int l = 0; l < `TRAINER_MAX_L; l++) begin
          db[l] <= '0;
          for (int x = 0; x < `TRAINER_MAX_X; x++) begin
            dw[l][x] <= '0;
          end
        end
      end

      ACC_MAC_W: begin
        dw[acc_cmd.l_idx][acc_cmd.x_idx] <= dw[acc_cmd.l_idx][acc_cmd.x_idx] + mac_term;
      end

      default: begin
        // Reads and NOP leave the sums alone
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Readout
  //////////////////////////////////////////////////

  // Output strobes, one cycle after the command
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_out_enable <= 1'b0;
      b_out_enable <= 1'b0;
    end else begin
      w_out_enable <= (acc_cmd.op == ACC_READ_W);
      b_out_enable <= (acc_cmd.op == ACC_READ_B);
    end
  end

  always_ff @(posedge CLK) begin
    if (acc_cmd.op == ACC_READ_W) begin
      w_out <= dw[acc_cmd.l_idx][acc_cmd.x_idx];  // Row-major walk from the controller
    end
    if (acc_cmd.op == ACC_READ_B) begin
      b_out <= db[acc_cmd.l_idx];
    end
  end

endmodule

// ==== trainer_controller.sv ====
//////////////////////////////////////////////////
// Trainer controller
// Phase FSM of a run: clear, per-step lane and
// input collection, drain, MAC sweep, readout
// and the closing ready pulse
//////////////////////////////////////////////////

`include "trainer_settings.svh"

module trainer_controller (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  trainer_pkg::sizes_t   sizes,
  input  logic                  lane_enable,
  input  trainer_pkg::data_t    x_in,
  input  logic                  x_enable,
  output logic                  lane_accept,
  output trainer_pkg::lidx_t    lane_tag,
  output trainer_pkg::x_beat_t  x_beat,
  output trainer_pkg::acc_cmd_t acc_cmd,
  output logic                  ready
);

  import trainer_pkg::*;

  localparam int DRAIN_LAST = `TRAINER_DELTA_LAT - 1;

  phase_t     phase;
  sizes_t     sizes_q;      // Sizes latched on start
  logic [2:0] lane_cnt;     // Lane beats taken this step
  logic [2:0] x_cnt;        // Input beats taken this step
  logic [2:0] lane_target;
  logic [2:0] x_target;
  logic       lane_full;
  logic       x_full;
  logic       lane_fill;    // Lanes complete after this edge
  logic       x_fill;
  logic       x_accept;
  step_t      step_cnt;
  logic [1:0] drain_cnt;
  lidx_t      cmd_l;        // Command walk, MAC and readout
  xidx_t      cmd_x;
  logic       row_end;
  logic       grid_end;

  // Registered input beat
  logic  x_valid_q;
  xidx_t x_idx_q;
  data_t x_val_q;

  //////////////////////////////////////////////////
  // Beat acceptance
  //////////////////////////////////////////////////

  assign lane_target = {1'b0, sizes_q.size_l} + 3'd1;
  assign x_target    = {1'b0, sizes_q.size_x} + 3'd1;
  assign lane_full   = (lane_cnt == lane_target);
  assign x_full      = (x_cnt == x_target);

  // Only in LANE_PHASE and only up to the count
  assign lane_accept = (phase == LANE_PHASE) && lane_enable && !lane_full;
  assign x_accept    = (phase == LANE_PHASE) && x_enable && !x_full;
  assign lane_tag    = lane_cnt[1:0];  // Lanes arrive in index order

  assign lane_fill = lane_full || (lane_accept && (lane_cnt + 3'd1 == lane_target));
  assign x_fill    = x_full || (x_accept && (x_cnt + 3'd1 == x_target));

  assign row_end  = (cmd_x == sizes_q.size_x);
  assign grid_end = row_end && (cmd_l == sizes_q.size_l);

  //////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase     <= IDLE_PHASE;
      sizes_q   <= '0;
      lane_cnt  <= '0;
      x_cnt     <= '0;
      step_cnt  <= '0;
      drain_cnt <= '0;
      cmd_l     <= '0;
      cmd_x     <= '0;
    end else begin
      if (lane_accept) lane_cnt <= lane_cnt + 3'd1;
      if (x_accept) x_cnt <= x_cnt + 3'd1;

      case (phase)
        IDLE_PHASE: begin
          if (start) begin
            sizes_q  <= sizes;
            step_cnt <= '0;
            phase    <= CLEAR_PHASE;
          end
        end

        CLEAR_PHASE: begin  // ACC_CLEAR goes out this cycle
          lane_cnt <= '0;
          x_cnt    <= '0;
          phase    <= LANE_PHASE;
        end

        LANE_PHASE: begin
          if (lane_fill && x_fill) begin
            drain_cnt <= '0;
            phase     <= DRAIN_PHASE;
          end
        end

        // Wait for the last delta to land in the buffer
        DRAIN_PHASE: begin
          drain_cnt <= drain_cnt + 2'd1;
          if (drain_cnt == DRAIN_LAST[1:0]) begin
            cmd_l <= '0;
            cmd_x <= '0;
            phase <= MAC_PHASE;
          end
        end

        // Both sweep the L x X grid, input index fastest
        MAC_PHASE, READ_W_PHASE: begin
          cmd_x <= row_end ? '0 : cmd_x + 2'd1;
          if (row_end) cmd_l <= grid_end ? '0 : cmd_l + 2'd1;

          if (grid_end && (phase == READ_W_PHASE)) begin
            phase <= READ_B_PHASE;
          end else if (grid_end) begin
            // End of one time step
            step_cnt <= step_cnt + 4'd1;
            lane_cnt <= '0;
            x_cnt    <= '0;
            if (step_cnt + 4'd1 >= sizes_q.size_t) phase <= READ_W_PHASE;
            else phase <= LANE_PHASE;
          end
        end

        READ_B_PHASE: begin
          cmd_l <= (cmd_l == sizes_q.size_l) ? '0 : cmd_l + 2'd1;
          if (cmd_l == sizes_q.size_l) phase <= DONE_PHASE;
        end

        DONE_PHASE: phase <= IDLE_PHASE;  // Last b_out beat is out now

        default: phase <= IDLE_PHASE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Command issue
  //////////////////////////////////////////////////

  always_comb begin
    acc_cmd = '{op: ACC_NOP, l_idx: cmd_l, x_idx: cmd_x};
    case (phase)
      CLEAR_PHASE:  acc_cmd.op = ACC_CLEAR;
      MAC_PHASE:    acc_cmd.op = ACC_MAC_W;
      READ_W_PHASE: acc_cmd.op = ACC_READ_W;
      READ_B_PHASE: acc_cmd.op = ACC_READ_B;
      default:      acc_cmd.op = ACC_NOP;
    endcase
  end

  // Ready two cycles after the last READ_B
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready     <= 1'b0;
      x_valid_q <= 1'b0;
    end else begin
      ready     <= (phase == DONE_PHASE);
      x_valid_q <= x_accept;
    end
  end

  always_ff @(posedge CLK) begin
    x_idx_q <= x_cnt[1:0];
    x_val_q <= x_in;
  end

  assign x_beat = '{valid: x_valid_q, index: x_idx_q, value: x_val_q};

endmodule

// ==== activation_trainer.sv ====
//////////////////////////////////////////////////
// Activation trainer top level
// Backward pass of one recurrent controller layer:
// delta, input-weight gradient and bias gradient
//////////////////////////////////////////////////

module activation_trainer (
  input  logic                CLK,
  input  logic                RST,
  input  logic                start,
  input  trainer_pkg::sizes_t sizes,
  input  trainer_pkg::lane_t  lane_in,
  input  logic                lane_enable,
  input  trainer_pkg::data_t  x_in,
  input  logic                x_enable,
  output trainer_pkg::data_t  w_out,
  output logic                w_out_enable,
  output trainer_pkg::data_t  b_out,
  output logic                b_out_enable,
  output logic                ready
);

  import trainer_pkg::*;

  logic        lane_accept;  // Gated lane strobe
  lidx_t       lane_tag;
  delta_beat_t delta_beat;
  x_beat_t     x_beat;
  acc_cmd_t    acc_cmd;

  // Phase control and beat gating
  trainer_controller u_controller (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .sizes      (sizes),
    .lane_enable(lane_enable),
    .x_in       (x_in),
    .x_enable   (x_enable),
    .lane_accept(lane_accept),
    .lane_tag   (lane_tag),
    .x_beat     (x_beat),
    .acc_cmd    (acc_cmd),
    .ready      (ready)
  );

  // Per-lane delta
  activation_delta u_delta (
    .CLK        (CLK),
    .RST        (RST),
    .lane_in    (lane_in),
    .lane_enable(lane_accept),
    .lane_tag   (lane_tag),
    .delta_beat (delta_beat)
  );

  // dW and db sums plus readout
  gradient_accumulator u_accumulator (
    .CLK         (CLK),
    .RST         (RST),
    .delta_beat  (delta_beat),
    .x_beat      (x_beat),
    .acc_cmd     (acc_cmd),
    .w_out       (w_out),
    .w_out_enable(w_out_enable),
    .b_out       (b_out),
    .b_out_enable(b_out_enable)
  );

endmodule

// ==== tb_activation_trainer.sv ====
//////////////////////////////////////////////////
// Activation trainer testbench
// Table-driven runs checked against a fixed-point
// model, with random data, beat gaps and a watchdog
//////////////////////////////////////////////////

`include "trainer_settings.svh"

module tb_activation_trainer;

  import trainer_pkg::*;

  localparam int NUM_CASES = 9;
  localparam int LAT       = `TRAINER_DELTA_LAT;

  // Table row with hand-worked results on the fixed L=1 X=1 rows
  typedef struct packed {
    logic [2:0] nl;     // Lanes
    logic [2:0] nx;     // Inputs
    logic [3:0] nt;     // Steps
    logic [1:0] gap;    // 0 back-to-back, 1 random gaps, 2 alternating
    logic       rnd;    // Random data
    logic       reuse;  // Same data as the last fresh row
    data_t      a;
    data_t      i;
    data_t      s;
    data_t      x;
    data_t      exp_db;
    data_t      exp_dw;
  } case_t;

  case_t cases [NUM_CASES] = '{
    '{3'd1, 3'd1, 4'd1, 2'd0, 1'b0, 1'b0, 16'h0080, 16'h0100, 16'h0200, 16'h0100,
      16'h0180, 16'h0180},
    '{3'd1, 3'd1, 4'd1, 2'd1, 1'b0, 1'b0, 16'hff80, 16'h0180, 16'hff00, 16'hfe00,
      16'hfee0, 16'h0240},  // Negative a, s and x
    '{3'd1, 3'd1, 4'd1, 2'd2, 1'b0, 1'b0, 16'h0000, 16'h7f00, 16'h0400, 16'h0300,
      16'hfc00, 16'hf400},  // s*i wraps
    '{3'd1, 3'd1, 4'd1, 2'd0, 1'b0, 1'b0, 16'h0180, 16'h00c1, 16'h0180, 16'h0101,
      16'hfe96, 16'hfe94},  // Inexact products floor toward minus
    '{3'd4, 3'd4, 4'd6, 2'd0, 1'b1, 1'b0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
    '{3'd4, 3'd4, 4'd6, 2'd1, 1'b1, 1'b1, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
    '{3'd4, 3'd4, 4'd6, 2'd2, 1'b1, 1'b1, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
    '{3'd3, 3'd2, 4'd3, 2'd1, 1'b1, 1'b0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
    '{3'd4, 3'd4, 4'd15, 2'd0, 1'b1, 1'b0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0}
  };

  logic   CLK;
  logic   RST;
  logic   start;
  sizes_t sizes;
  lane_t  lane_in;
  logic   lane_enable;
  data_t  x_in;
  logic   x_enable;
  data_t  w_out;
  logic   w_out_enable;
  data_t  b_out;
  logic   b_out_enable;
  logic   ready;

  // Stimulus of the current case
  data_t st_a [`TRAINER_MAX_T][`TRAINER_MAX_L];
  data_t st_i [`TRAINER_MAX_T][`TRAINER_MAX_L];
  data_t st_s [`TRAINER_MAX_T][`TRAINER_MAX_L];
  data_t st_x [`TRAINER_MAX_T][`TRAINER_MAX_X];

  // Model sums and the beats still owed by the DUT
  data_t mdw [`TRAINER_MAX_L][`TRAINER_MAX_X];
  data_t mdb [`TRAINER_MAX_L];
  data_t w_q [$];
  data_t b_q [$];

  logic [31:0] data_state;   // Data stream
  logic [31:0] saved_state;  // Replay point for reused rows
  logic [31:0] gap_state;    // Gaps and junk beats
  logic        run_active;
  logic        prev_b_en;
  int          ready_count;

  activation_trainer DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Random numbers and model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg(input logic [31:0] st);
    return st * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic data_t rand_word();
    data_state = lcg(data_state);
    return data_t'(data_state[31:16]);  // Upper bits have the longer period
  endfunction

  function automatic data_t junk_word();
    gap_state = lcg(gap_state);
    return data_t'(gap_state[31:16]);
  endfunction

  // Q7.8 product by floor shift and low word
  function automatic data_t q_mul(input data_t p, input data_t q);
    longint full;
    full = longint'(p) * longint'(q);
    return data_t'(full >>> `TRAINER_FRAC_W);
  endfunction

  function automatic data_t lane_delta(input data_t a, input data_t i, input data_t s);
    data_t gate;
    gate = 16'sd256 - q_mul(a, a);  // 1 - a^2 with wrap
    return q_mul(q_mul(s, i), gate);
  endfunction

  function automatic int estimate_cycles();
    int total;
    int lx;
    total = 64;  // Reset and idle window
    for (int c = 0; c < NUM_CASES; c++) begin
      lx = cases[c].nl * cases[c].nx;
      total += cases[c].nt * (4 * (cases[c].nl + cases[c].nx) + LAT + lx);
      total += lx + cases[c].nl + 8;  // Readout and ready
    end
    return total;
  endfunction

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Outputs sampled on the falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (!run_active && (w_out_enable || b_out_enable || ready)) begin
        abort_run("An output strobe came while no run was active");
      end else begin
        if (w_out_enable) begin
          if (w_q.size() == 0) abort_run("The DUT sent more w_out beats than expected");
          else check_value("w_out", w_out, w_q.pop_front());
        end
        if (b_out_enable) begin
          check_value("w_out beats left at b_out", w_q.size(), 0);  // dW streams first
          if (b_q.size() == 0) abort_run("The DUT sent more b_out beats than expected");
          else check_value("b_out", b_out, b_q.pop_front());
        end
        if (ready) begin
          check_value("b_out_enable the cycle before ready", prev_b_en, 1);
          check_value("b_out beats left at ready", b_q.size(), 0);
          ready_count++;
          run_active = 1'b0;  // A second pulse now counts as idle activity
        end
      end
      prev_b_en = b_out_enable;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Builds data, runs the model and queues the expected beats
  task automatic load_case(input int c);
    case_t k;
    data_t d;
    k = cases[c];
    if (k.reuse) data_state = saved_state;
    else saved_state = data_state;
    for (int l = 0; l < `TRAINER_MAX_L; l++) begin
      mdb[l] = '0;
      for (int x = 0; x < `TRAINER_MAX_X; x++) mdw[l][x] = '0;
    end
    for (int t = 0; t < k.nt; t++) begin
      for (int l = 0; l < k.nl; l++) begin
        st_a[t][l] = k.rnd ? rand_word() : k.a;
        st_i[t][l] = k.rnd ? rand_word() : k.i;
        st_s[t][l] = k.rnd ? rand_word() : k.s;
      end
      for (int x = 0; x < k.nx; x++) st_x[t][x] = k.rnd ? rand_word() : k.x;
      for (int l = 0; l < k.nl; l++) begin
        d = lane_delta(st_a[t][l], st_i[t][l], st_s[t][l]);
        mdb[l] = mdb[l] + d;
        for (int x = 0; x < k.nx; x++) mdw[l][x] = mdw[l][x] + q_mul(d, st_x[t][x]);
      end
    end
    if (!k.rnd) begin  // Model against the hand-worked row
      check_value("model db", mdb[0], k.exp_db);
      check_value("model dW", mdw[0][0], k.exp_dw);
    end
    for (int l = 0; l < k.nl; l++) begin
      for (int x = 0; x < k.nx; x++) w_q.push_back(mdw[l][x]);  // Row-major
    end
    for (int l = 0; l < k.nl; l++) b_q.push_back(mdb[l]);
  endtask

  // One step of lane and input beats followed by the drain and MAC window
  task automatic drive_step(input int t, input case_t k);
    int    li;
    int    xi;
    int    cyc;
    logic  lane_go;
    logic  x_go;
    data_t w;
    li  = 0;
    xi  = 0;
    cyc = 0;
    while (li < k.nl || xi < k.nx) begin
      @(negedge CLK);
      w = junk_word();
      case (k.gap)
        2'd0: begin
          lane_go = (li < k.nl);
          x_go    = (xi < k.nx);
        end
        2'd1: begin
          lane_go = w[15];
          x_go    = w[14];
        end
        default: begin
          lane_go = !cyc[0];
          x_go    = cyc[0];
        end
      endcase
      lane_enable = lane_go;
      x_enable    = x_go;
      lane_in     = '{a: w, i: ~w, s: w ^ 16'h5a5a};  // Junk past the count
      x_in        = ~w;
      if (lane_go && li < k.nl) begin
        lane_in = '{a: st_a[t][li], i: st_i[t][li], s: st_s[t][li]};
        li++;
      end
      if (x_go && xi < k.nx) begin
        x_in = st_x[t][xi];
        xi++;
      end
      cyc++;
    end
    // Gap rows send beats here that the DUT drops outside LANE_PHASE
    repeat (LAT + k.nl * k.nx) begin
      @(negedge CLK);
      w           = junk_word();
      lane_enable = (k.gap != 2'd0);
      x_enable    = (k.gap != 2'd0);
      lane_in     = '{a: w, i: w, s: ~w};
      x_in        = w;
    end
  endtask

  task automatic run_case(input int c);
    case_t k;
    k = cases[c];
    load_case(c);
    @(negedge CLK);
    sizes      = '{size_l: lidx_t'(k.nl - 3'd1), size_x: xidx_t'(k.nx - 3'd1), size_t: k.nt};
    start      = 1'b1;
    run_active = 1'b1;
    @(negedge CLK);  // CLEAR_PHASE
    start       = 1'b0;
    lane_enable = (k.gap != 2'd0);
    x_enable    = (k.gap != 2'd0);
    for (int t = 0; t < k.nt; t++) drive_step(t, k);
    lane_enable = 1'b0;
    x_enable    = 1'b0;
    while (ready !== 1'b1) @(negedge CLK);  // Watchdog bounds this
    @(negedge CLK);  // Idle cycle where a second ready would show
  endtask

  initial begin
    RST         = 1'b1;
    start       = 1'b0;
    sizes       = '0;
    lane_in     = '0;
    lane_enable = 1'b0;
    x_in        = '0;
    x_enable    = 1'b0;
    data_state  = 32'hc050e9c9;
    saved_state = 32'hc050e9c9;
    gap_state   = lcg(32'hc050e9c9);
    run_active  = 1'b0;
    prev_b_en   = 1'b0;
    ready_count = 0;
    repeat (16) @(posedge CLK);  // Reset held over 16 rising edges
    @(negedge CLK);
    RST = 1'b0;
    repeat (8) @(negedge CLK);  // Idle window where any strobe is flagged
    check_value("ready while idle", ready, 0);
    for (int c = 0; c < NUM_CASES; c++) run_case(c);
    repeat (4) @(negedge CLK);
    if (ready_count == NUM_CASES && w_q.size() == 0 && b_q.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run("The run ended with ready pulses or output beats missing");
    end
  end

  // Watchdog
  initial begin
    int limit;
    limit = 2 * estimate_cycles() * 4;
    #(limit);
    abort_run("Timeout: the DUT did not finish all runs in the expected time");
  end

endmodule

// ==== files.f ====
+incdir+.
trainer_pkg.sv
activation_delta.sv
gradient_accumulator.sv
trainer_controller.sv
activation_trainer.sv
tb_activation_trainer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the activation trainer testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_activation_trainer \
  -f files.f -Mdir obj_dir -o tb_activation_trainer

# A failing run exits non-zero, the log search decides the result
./obj_dir/tb_activation_trainer > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qxF '** PASS **' "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
